// File: bench/clk_gen.sv
`default_nettype none

module clk_gen #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: bench/dmem_sys_properties.sv
`default_nettype none

module dmem_sys_properties (
  input logic            clk,
  input logic            rst,
  input logic            dma_rd_resp_valid,
  input logic            dma_rd_resp_ready,
  input dmem_pkg::line_t dma_rd_resp_data,
  input logic            core_en,
  input logic            core_wen,
  input logic            core_rd_valid,
  input logic            dma_wr_ready,
  input logic            dma_rd_ready
);

  int unsigned prop_errors;

  initial begin
    prop_errors = 0;
  end

  // A held response keeps its data until the consumer takes it
  resp_stable: assert property (@(posedge clk) disable iff (rst)
    (dma_rd_resp_valid && !dma_rd_resp_ready) |=>
    (dma_rd_resp_valid && $stable(dma_rd_resp_data)))
  else begin
    $error("Read response changed while it was held");
    prop_errors++;
  end

  core_rd_timing: assert property (@(posedge clk) disable iff (rst)
    core_rd_valid == $past(core_en && !core_wen))
  else begin
    $error("core_rd_valid does not follow a core read by one cycle");
    prop_errors++;
  end

  readies_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> (dma_wr_ready && dma_rd_ready))
  else begin
    $error("DMA readies were not high after reset");
    prop_errors++;
  end

endmodule

bind dmem_sys dmem_sys_properties i_dmem_sys_properties (
  .clk               (clk),
  .rst               (rst),
  .dma_rd_resp_valid (dma_rd_resp_valid),
  .dma_rd_resp_ready (dma_rd_resp_ready),
  .dma_rd_resp_data  (dma_rd_resp_data),
  .core_en           (core_en),
  .core_wen          (core_wen),
  .core_rd_valid     (core_rd_valid),
  .dma_wr_ready      (dma_wr_ready),
  .dma_rd_ready      (dma_rd_ready)
);

`default_nettype wire

// File: bench/dmem_sys_tb.sv
`default_nettype none

module dmem_sys_tb;

  import dmem_pkg::*;

  localparam int unsigned SEED       = 50;
  localparam int unsigned WAIT_LIMIT = 200;
  localparam int unsigned NUM_LINES  = 12;
  localparam int unsigned NUM_WORDS  = 16;
  localparam int unsigned NUM_MSGS   = 10;
  localparam int unsigned NUM_STREAM = 24;

  logic        clk;
  logic        rst;
  logic        dma_wr_valid;
  dma_wr_req_t dma_wr_req;
  logic        dma_wr_last;
  logic        dma_wr_ready;
  logic        dma_rd_valid;
  dmem_addr_t  dma_rd_addr;
  logic        dma_rd_last;
  logic        dma_rd_ready;
  logic        dma_rd_resp_valid;
  line_t       dma_rd_resp_data;
  logic        dma_rd_resp_ready;
  logic        core_en;
  logic        core_wen;
  word_strb_t  core_strb;
  dmem_addr_t  core_addr;
  word_t       core_wr_data;
  word_t       core_rd_data;
  logic        core_rd_valid;
  logic        bc_msg_in_valid;
  bc_msg_t     bc_msg_in;
  logic        bc_msg_valid;
  dmem_addr_t  bc_msg_addr;

  // Byte-wide reference image of the whole data memory
  logic [7:0]  model_mem [DMEM_SIZE];
  line_t       exp_q [$];
  dmem_addr_t  dma_lines [$];
  dmem_addr_t  core_words [$];
  int unsigned checks;
  int unsigned errors;

  clk_gen #(.PERIOD(10)) i_clk_gen (.clk(clk));

  dmem_sys #(
    .DATA_DEPTH_LOG (2),
    .RESP_DEPTH_LOG (3)
  ) i_dmem_sys (
    .clk               (clk),
    .rst               (rst),
    .dma_wr_valid      (dma_wr_valid),
    .dma_wr_req        (dma_wr_req),
    .dma_wr_last       (dma_wr_last),
    .dma_wr_ready      (dma_wr_ready),
    .dma_rd_valid      (dma_rd_valid),
    .dma_rd_addr       (dma_rd_addr),
    .dma_rd_last       (dma_rd_last),
    .dma_rd_ready      (dma_rd_ready),
    .dma_rd_resp_valid (dma_rd_resp_valid),
    .dma_rd_resp_data  (dma_rd_resp_data),
    .dma_rd_resp_ready (dma_rd_resp_ready),
    .core_en           (core_en),
    .core_wen          (core_wen),
    .core_strb         (core_strb),
    .core_addr         (core_addr),
    .core_wr_data      (core_wr_data),
    .core_rd_data      (core_rd_data),
    .core_rd_valid     (core_rd_valid),
    .bc_msg_in_valid   (bc_msg_in_valid),
    .bc_msg_in         (bc_msg_in),
    .bc_msg_valid      (bc_msg_valid),
    .bc_msg_addr       (bc_msg_addr)
  );

  //////////////////////////////
  // Checks and reference model
  //////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // Byte i of a line or word lives at base + i
  function automatic void model_write(input int unsigned base, input int unsigned nbytes,
                                      input line_strb_t strb, input line_t data);
    for (int i = 0; i < nbytes; i++) begin
      if (strb[i]) begin
        model_mem[base + i] = data[8*i +: 8];
      end
    end
  endfunction

  function automatic line_t model_read(input int unsigned base, input int unsigned nbytes);
    line_t result;
    result = '0;
    for (int i = 0; i < nbytes; i++) begin
      result[8*i +: 8] = model_mem[base + i];
    end
    return result;
  endfunction

  function automatic dmem_addr_t pick_dma_line();
    return dma_lines[$urandom_range(0, dma_lines.size() - 1)];
  endfunction

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  task automatic skip_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
  endtask

  task automatic dma_write(input dmem_addr_t addr, input line_strb_t strb, input line_t data);
    dma_wr_req_t req;
    int unsigned n;
    req.addr = addr;
    req.strb = strb;
    req.data = data;
    n = 0;
    @(posedge clk);
    dma_wr_valid <= 1'b1;
    dma_wr_req   <= req;
    dma_wr_last  <= 1'b1;
    @(negedge clk);
    while (!dma_wr_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expect_true(dma_wr_ready, "DMA write command was never accepted");
    @(posedge clk);
    dma_wr_valid <= 1'b0;
    model_write(addr, 8, strb, data);
  endtask

  task automatic dma_read_cmd(input dmem_addr_t addr);
    int unsigned n;
    n = 0;
    @(posedge clk);
    dma_rd_valid <= 1'b1;
    dma_rd_addr  <= addr;
    dma_rd_last  <= 1'b1;
    @(negedge clk);
    while (!dma_rd_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expect_true(dma_rd_ready, "DMA read command was never accepted");
    @(posedge clk);
    dma_rd_valid <= 1'b0;
  endtask

  // Expects dma_rd_resp_ready to be high
  task automatic read_response(input line_t exp);
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (!dma_rd_resp_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expect_true(dma_rd_resp_valid, "No DMA read response arrived");
    check_value("dma_rd_resp_data", dma_rd_resp_data, exp);
    @(posedge clk);
  endtask

  task automatic core_write(input dmem_addr_t addr, input word_strb_t strb, input word_t data);
    @(posedge clk);
    core_en      <= 1'b1;
    core_wen     <= 1'b1;
    core_strb    <= strb;
    core_addr    <= addr;
    core_wr_data <= data;
    @(posedge clk);
    core_en  <= 1'b0;
    core_wen <= 1'b0;
    model_write(addr, 4, strb, data);
  endtask

  task automatic core_read_check(input dmem_addr_t addr);
    @(posedge clk);
    core_en   <= 1'b1;
    core_wen  <= 1'b0;
    core_addr <= addr;
    @(negedge clk);
    expect_true(!core_rd_valid, "core_rd_valid was high in the request cycle");
    @(posedge clk);
    core_en <= 1'b0;
    @(negedge clk);
    expect_true(core_rd_valid, "core_rd_valid was low one cycle after the read");
    check_value("core_rd_data", core_rd_data, model_read(addr, 4));
  endtask

  task automatic send_broadcast(input logic [MSG_IDX_W-1:0] idx, input word_strb_t strb,
                                input word_t data);
    bc_msg_t     msg;
    int unsigned lat;
    msg.idx  = idx;
    msg.strb = strb;
    msg.data = data;
    @(posedge clk);
    bc_msg_in_valid <= 1'b1;
    bc_msg_in       <= msg;
    @(posedge clk);
    bc_msg_in_valid <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!bc_msg_valid && lat < WAIT_LIMIT) begin
      @(negedge clk);
      lat++;
    end
    expect_true(lat == 3, "bc_msg_valid did not follow the message by 3 cycles");
    check_value("bc_msg_addr", bc_msg_addr, BC_BASE + 4 * idx);
    model_write(BC_BASE + 4 * idx, 4, strb, data);
  endtask

  // Issues reads with responses held back until the read FIFO refuses one
  task automatic fill_until_stall();
    dmem_addr_t  addr;
    int unsigned n;
    logic        stalled;
    n = 0;
    stalled = 1'b0;
    addr = pick_dma_line();
    @(posedge clk);
    dma_rd_resp_ready <= 1'b0;
    dma_rd_valid      <= 1'b1;
    dma_rd_addr       <= addr;
    while (!stalled && n < WAIT_LIMIT) begin
      @(negedge clk);
      if (dma_rd_ready) begin
        exp_q.push_back(model_read(addr, 8));
        addr = pick_dma_line();
        @(posedge clk);
        dma_rd_addr <= addr;
        n++;
      end else begin
        stalled = 1'b1;
      end
    end
    @(posedge clk);
    dma_rd_valid <= 1'b0;
    expect_true(stalled, "dma_rd_ready never dropped while responses were held back");
  endtask

  task automatic collect_responses(input int unsigned total);
    int unsigned got;
    int unsigned idle;
    got = 0;
    idle = 0;
    while (got < total && idle < WAIT_LIMIT) begin
      @(posedge clk);
      dma_rd_resp_ready <= ($urandom_range(0, 3) != 0);
      @(negedge clk);
      if (dma_rd_resp_valid && dma_rd_resp_ready) begin
        expect_true(exp_q.size() != 0, "DMA read response arrived with no read outstanding");
        if (exp_q.size() != 0) begin
          check_value("dma_rd_resp_data", dma_rd_resp_data, exp_q.pop_front());
        end
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    expect_true(got == total, "DMA read responses went missing before the timeout");
    @(posedge clk);
    dma_rd_resp_ready <= 1'b1;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    dmem_addr_t            addr;
    logic [MSG_IDX_W-1:0]  idx;
    int unsigned           total;
    int unsigned           prop_fails;
    void'($urandom(SEED));
    checks            = 0;
    errors            = 0;
    rst               = 1'b1;
    dma_wr_valid      = 1'b0;
    dma_wr_req        = '0;
    dma_wr_last       = 1'b0;
    dma_rd_valid      = 1'b0;
    dma_rd_addr       = '0;
    dma_rd_last       = 1'b0;
    dma_rd_resp_ready = 1'b1;
    core_en           = 1'b0;
    core_wen          = 1'b0;
    core_strb         = '0;
    core_addr         = '0;
    core_wr_data      = '0;
    bc_msg_in_valid   = 1'b0;
    bc_msg_in         = '0;

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    expect_true(!dma_rd_resp_valid && !core_rd_valid && !bc_msg_valid,
                "A valid output was high right after reset");
    expect_true(dma_wr_ready && dma_rd_ready, "A DMA ready was low right after reset");

    // DMA lines live in the lowest 8 KB, each one fully written before a strobed update
    repeat (NUM_LINES) begin
      addr = dmem_addr_t'($urandom_range(0, 1023) * 8);
      dma_lines.push_back(addr);
      dma_write(addr, 8'hff, {$urandom, $urandom});
    end
    foreach (dma_lines[i]) begin
      dma_write(dma_lines[i], line_strb_t'($urandom_range(0, 255)), {$urandom, $urandom});
    end
    // Let the write FIFO drain before reading back
    skip_cycles(8);
    foreach (dma_lines[i]) begin
      dma_read_cmd(dma_lines[i]);
      read_response(model_read(dma_lines[i], 8));
    end

    // Core words sit in the next 8 KB so they never share a line with DMA
    repeat (NUM_WORDS) begin
      addr = dmem_addr_t'(8192 + 4 * $urandom_range(0, 2047));
      core_words.push_back(addr);
      core_write(addr, 4'hf, $urandom);
    end
    foreach (core_words[i]) begin
      core_write(core_words[i], word_strb_t'($urandom_range(0, 15)), $urandom);
    end
    foreach (core_words[i]) begin
      core_read_check(core_words[i]);
    end

    repeat (NUM_MSGS) begin
      idx = MSG_IDX_W'($urandom_range(0, 1023));
      addr = dmem_addr_t'(BC_BASE + 4 * idx);
      core_write(addr, 4'hf, $urandom);
      send_broadcast(idx, word_strb_t'($urandom_range(0, 15)), $urandom);
      core_read_check(addr);
    end

    fill_until_stall();
    total = exp_q.size() + NUM_STREAM;
    fork
      begin
        repeat (NUM_STREAM) begin
          addr = pick_dma_line();
          exp_q.push_back(model_read(addr, 8));
          dma_read_cmd(addr);
        end
      end
      collect_responses(total);
    join
    skip_cycles(4);
    expect_true(!dma_rd_resp_valid, "An extra DMA read response appeared");

    prop_fails = i_dmem_sys.i_dmem_sys_properties.prop_errors;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: common/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

  //////////////////////////////
  // Sizes and widths
  //////////////////////////////

  localparam int unsigned LINE_W         = 64;
  localparam int unsigned WORD_W         = 32;
  localparam int unsigned DMEM_SIZE      = 32768;
  localparam int unsigned BC_REGION_SIZE = 4096;
  localparam int unsigned BC_BASE        = DMEM_SIZE - BC_REGION_SIZE;
  localparam int unsigned LINE_ADDR_BITS = 3;
  localparam int unsigned DMEM_ADDR_W    = 15;
  localparam int unsigned MSG_IDX_W      = 10;

  // One bank bit sits just above the byte-in-line bits
  localparam int unsigned BANK_IDX_W = DMEM_ADDR_W - LINE_ADDR_BITS - 1;
  localparam int unsigned BANK_LINES = 2 ** BANK_IDX_W;

  typedef logic [LINE_W-1:0]        line_t;
  typedef logic [WORD_W-1:0]        word_t;
  typedef logic [LINE_W/8-1:0]      line_strb_t;
  typedef logic [WORD_W/8-1:0]      word_strb_t;
  typedef logic [DMEM_ADDR_W-1:0]   dmem_addr_t;
  typedef logic [BANK_IDX_W-1:0]    bank_idx_t;

  //////////////////////////////
  // Bundled payloads
  //////////////////////////////

  // Broadcast message as it arrives from the core side
  typedef struct packed {
    logic [MSG_IDX_W-1:0] idx;
    word_strb_t           strb;
    word_t                data;
  } bc_msg_t;

  typedef struct packed {
    dmem_addr_t addr;
    line_strb_t strb;
    line_t      data;
  } dma_wr_req_t;

  // One bank port access; en marks a write, idx also addresses reads
  typedef struct packed {
    logic       en;
    line_strb_t wen;
    bank_idx_t  idx;
    line_t      data;
  } bank_wr_t;

  // Line index inside the bank chosen by the bank bit
  function automatic bank_idx_t line_idx(input dmem_addr_t addr);
    return addr[DMEM_ADDR_W-1:LINE_ADDR_BITS+1];
  endfunction

endpackage

`default_nettype wire

// File: dmem/dmem_bank.sv
`default_nettype none

module dmem_bank (
  input  logic                 clk,

  // DMA and broadcast side
  input  dmem_pkg::bank_wr_t   a_wr,
  input  logic                 a_rd_en,
  output dmem_pkg::line_t      a_rd_data,

  // Core side
  input  logic                 b_en,
  input  dmem_pkg::line_strb_t b_wen,
  input  dmem_pkg::bank_idx_t  b_idx,
  input  dmem_pkg::line_t      b_wr_data,
  output dmem_pkg::line_t      b_rd_data
);

  import dmem_pkg::*;

  line_t mem [BANK_LINES];

  // Both ports follow the usual true dual-port block RAM template
  always @(posedge clk) begin
    if (a_wr.en) begin
      for (int i = 0; i < LINE_W/8; i++) begin
        if (a_wr.wen[i]) begin
          mem[a_wr.idx][8*i +: 8] <= a_wr.data[8*i +: 8];
        end
      end
    end
    if (a_rd_en) begin
      a_rd_data <= mem[a_wr.idx];
    end
  end

  // A core write also reads the old line, the port logic ignores it
  always @(posedge clk) begin
    if (b_en) begin
      for (int i = 0; i < LINE_W/8; i++) begin
        if (b_wen[i]) begin
          mem[b_idx][8*i +: 8] <= b_wr_data[8*i +: 8];
        end
      end
      b_rd_data <= mem[b_idx];
    end
  end

endmodule

`default_nettype wire

// File: dmem/dmem_bank_arb.sv
`default_nettype none

module dmem_bank_arb #(
  parameter bit BANK_ID = 1'b0
) (
  input  dmem_pkg::bank_wr_t    bc_wr,
  input  dmem_pkg::dmem_addr_t  bc_addr,

  input  logic                  wr_valid,
  input  dmem_pkg::dma_wr_req_t wr_head,

  input  logic                  rd_valid,
  input  dmem_pkg::dmem_addr_t  rd_head,
  input  logic                  rd_room,

  output logic                  wr_gnt,
  output logic                  rd_gnt,

  output dmem_pkg::bank_wr_t    port_wr,
  output logic                  port_rd_en
);

  import dmem_pkg::*;

  logic bc_hit;
  logic wr_hit;
  logic rd_hit;

  // Each request only counts here if its bank bit points at this bank
  assign bc_hit = bc_wr.en && (bc_addr[LINE_ADDR_BITS] == BANK_ID);
  assign wr_hit = wr_valid && (wr_head.addr[LINE_ADDR_BITS] == BANK_ID);
  assign rd_hit = rd_valid && (rd_head[LINE_ADDR_BITS] == BANK_ID);

  // Broadcast writes have no back-pressure, so they always go first.
  // DMA writes come next to drain the distribution network quickly
  always_comb begin
    wr_gnt       = 1'b0;
    rd_gnt       = 1'b0;
    port_rd_en   = 1'b0;
    port_wr.en   = 1'b0;
    port_wr.wen  = wr_head.strb;
    port_wr.idx  = line_idx(wr_head.addr);
    port_wr.data = wr_head.data;

    if (bc_hit) begin
      port_wr = bc_wr;
    end else if (wr_hit) begin
      port_wr.en = 1'b1;
      wr_gnt     = 1'b1;
    end else if (rd_hit && rd_room) begin
      // Reads share the index field of the port
      port_wr.idx = line_idx(rd_head);
      rd_gnt      = 1'b1;
      port_rd_en  = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/bc_msg_stage.sv
`default_nettype none

module bc_msg_stage (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  msg_valid,
  input  dmem_pkg::bc_msg_t     msg,

  output dmem_pkg::bank_wr_t    bank_wr,
  output dmem_pkg::dmem_addr_t  wr_addr,

  output dmem_pkg::dmem_addr_t  msg_addr,
  output logic                  msg_addr_valid
);

  import dmem_pkg::*;

  bc_msg_t    msg_r;
  logic       valid_r;
  dmem_addr_t addr_s1;
  logic       valid_rr;
  dmem_addr_t addr_rr;
  line_strb_t strb_rr;
  line_t      data_rr;

  // Stage 1 holds the raw message
  always_ff @(posedge clk) begin
    msg_r <= msg;
  end

  // Word index becomes a byte offset into the region at the top of the memory
  assign addr_s1 = dmem_addr_t'(BC_BASE) + dmem_addr_t'({msg_r.idx, 2'b00});

  // Stage 2 moves the word into its lane of the line
  always_ff @(posedge clk) begin
    addr_rr <= addr_s1;
    strb_rr <= line_strb_t'(msg_r.strb) << {addr_s1[2], 2'b00};
    data_rr <= line_t'(msg_r.data) << {addr_s1[2], 5'b00000};
  end

  always_ff @(posedge clk) begin
    msg_addr <= addr_rr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r        <= 1'b0;
      valid_rr       <= 1'b0;
      msg_addr_valid <= 1'b0;
    end else begin
      valid_r        <= msg_valid;
      valid_rr       <= valid_r;
      msg_addr_valid <= valid_rr;
    end
  end

  // The bank bit lives in wr_addr, each arbiter checks it against its own bank
  assign bank_wr.en   = valid_rr;
  assign bank_wr.wen  = strb_rr;
  assign bank_wr.idx  = line_idx(addr_rr);
  assign bank_wr.data = data_rr;
  assign wr_addr      = addr_rr;

endmodule

`default_nettype wire

// File: hdl/core_lane_port.sv
`default_nettype none

module core_lane_port (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 core_en,
  input  logic                 core_wen,
  input  dmem_pkg::word_strb_t core_strb,
  input  dmem_pkg::dmem_addr_t core_addr,
  input  dmem_pkg::word_t      core_wr_data,
  output dmem_pkg::word_t      core_rd_data,
  output logic                 core_rd_valid,

  output dmem_pkg::bank_wr_t   bank0_b,
  output dmem_pkg::bank_wr_t   bank1_b,
  input  dmem_pkg::line_t      bank0_rd,
  input  dmem_pkg::line_t      bank1_rd
);

  import dmem_pkg::*;

  logic       lane;
  logic       bank;
  line_strb_t line_strb;
  line_t      line_data;
  logic       lane_r;
  logic       bank_r;
  line_t      rd_line;

  assign lane = core_addr[2];
  assign bank = core_addr[LINE_ADDR_BITS];

  // Word goes into the upper half of the line when address bit 2 is set
  assign line_strb = core_wen ? (line_strb_t'(core_strb) << {lane, 2'b00}) : '0;
  assign line_data = line_t'(core_wr_data) << {lane, 5'b00000};

  assign bank0_b.en   = core_en && !bank;
  assign bank0_b.wen  = line_strb;
  assign bank0_b.idx  = line_idx(core_addr);
  assign bank0_b.data = line_data;

  assign bank1_b.en   = core_en && bank;
  assign bank1_b.wen  = line_strb;
  assign bank1_b.idx  = line_idx(core_addr);
  assign bank1_b.data = line_data;

  //////////////////////////////
  // Read return
  //////////////////////////////

  always_ff @(posedge clk) begin
    lane_r <= lane;
    bank_r <= bank;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      core_rd_valid <= 1'b0;
    end else begin
      core_rd_valid <= core_en && !core_wen;
    end
  end

  assign rd_line      = bank_r ? bank1_rd : bank0_rd;
  assign core_rd_data = lane_r ? rd_line[LINE_W-1:WORD_W] : rd_line[WORD_W-1:0];

endmodule

`default_nettype wire

// File: hdl/dma_rd_return.sv
`default_nettype none

module dma_rd_return #(
  parameter int DEPTH_LOG = 3
) (
  input  logic            clk,
  input  logic            rst,

  input  logic            rd_gnt0,
  input  logic            rd_gnt1,
  input  dmem_pkg::line_t bank0_rd,
  input  dmem_pkg::line_t bank1_rd,
  output logic            rd_room,

  output logic            resp_valid,
  output dmem_pkg::line_t resp_data,
  input  logic            resp_ready
);

  import dmem_pkg::*;

  logic               gnt_r;
  logic               bank_r;
  line_t              push_data;
  logic [DEPTH_LOG:0] free_slots;

  // Only one bank can grant a read per cycle, the FIFO head has one bank bit
  always_ff @(posedge clk) begin
    if (rst) begin
      gnt_r  <= 1'b0;
      bank_r <= 1'b0;
    end else begin
      gnt_r  <= rd_gnt0 || rd_gnt1;
      bank_r <= rd_gnt1;
    end
  end

  // Bank read data is valid the cycle after the grant
  assign push_data = bank_r ? bank1_rd : bank0_rd;

  // A read granted last cycle still needs a slot before it lands
  assign rd_room = free_slots > {{DEPTH_LOG{1'b0}}, gnt_r};

  sync_fifo #(
    .DEPTH_LOG (DEPTH_LOG),
    .WIDTH     (LINE_W)
  ) i_resp_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (gnt_r),
    .in_data    (push_data),
    .in_ready   (),
    .out_valid  (resp_valid),
    .out_data   (resp_data),
    .out_ready  (resp_ready),
    .free_slots (free_slots)
  );

endmodule

`default_nettype wire

// File: hdl/dmem_sys.sv
`default_nettype none

module dmem_sys #(
  parameter int DATA_DEPTH_LOG = 2,
  parameter int RESP_DEPTH_LOG = 3
) (
  input  logic                  clk,
  input  logic                  rst,

  // Every beat is a full line request, so the last flags carry no framing here
  input  logic                  dma_wr_valid,
  input  dmem_pkg::dma_wr_req_t dma_wr_req,
  input  logic                  dma_wr_last,
  output logic                  dma_wr_ready,

  input  logic                  dma_rd_valid,
  input  dmem_pkg::dmem_addr_t  dma_rd_addr,
  input  logic                  dma_rd_last,
  output logic                  dma_rd_ready,

  output logic                  dma_rd_resp_valid,
  output dmem_pkg::line_t       dma_rd_resp_data,
  input  logic                  dma_rd_resp_ready,

  input  logic                  core_en,
  input  logic                  core_wen,
  input  dmem_pkg::word_strb_t  core_strb,
  input  dmem_pkg::dmem_addr_t  core_addr,
  input  dmem_pkg::word_t       core_wr_data,
  output dmem_pkg::word_t       core_rd_data,
  output logic                  core_rd_valid,

  input  logic                  bc_msg_in_valid,
  input  dmem_pkg::bc_msg_t     bc_msg_in,
  output logic                  bc_msg_valid,
  output dmem_pkg::dmem_addr_t  bc_msg_addr
);

  import dmem_pkg::*;

  dma_wr_req_t wr_head;
  logic        wr_head_valid;
  logic        wr_gnt0;
  logic        wr_gnt1;
  logic        wr_pop;
  dmem_addr_t  rd_head;
  logic        rd_head_valid;
  logic        rd_gnt0;
  logic        rd_gnt1;
  logic        rd_pop;
  logic        rd_room;
  bank_wr_t    bc_wr;
  dmem_addr_t  bc_wr_addr;
  bank_wr_t    port_wr0;
  bank_wr_t    port_wr1;
  logic        port_rd_en0;
  logic        port_rd_en1;
  bank_wr_t    core_b0;
  bank_wr_t    core_b1;
  line_t       bank0_a_rd;
  line_t       bank1_a_rd;
  line_t       bank0_b_rd;
  line_t       bank1_b_rd;

  //////////////////////////////
  // DMA request FIFOs
  //////////////////////////////

  // Only the arbiter owning the head's bank grants it
  assign wr_pop = wr_gnt0 | wr_gnt1;
  assign rd_pop = rd_gnt0 | rd_gnt1;

  sync_fifo #(
    .DEPTH_LOG (DATA_DEPTH_LOG),
    .WIDTH     ($bits(dma_wr_req_t))
  ) i_wr_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (dma_wr_valid),
    .in_data    (dma_wr_req),
    .in_ready   (dma_wr_ready),
    .out_valid  (wr_head_valid),
    .out_data   (wr_head),
    .out_ready  (wr_pop),
    .free_slots ()
  );

  sync_fifo #(
    .DEPTH_LOG (DATA_DEPTH_LOG),
    .WIDTH     (DMEM_ADDR_W)
  ) i_rd_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (dma_rd_valid),
    .in_data    (dma_rd_addr),
    .in_ready   (dma_rd_ready),
    .out_valid  (rd_head_valid),
    .out_data   (rd_head),
    .out_ready  (rd_pop),
    .free_slots ()
  );

  bc_msg_stage i_bc_msg_stage (
    .clk            (clk),
    .rst            (rst),
    .msg_valid      (bc_msg_in_valid),
    .msg            (bc_msg_in),
    .bank_wr        (bc_wr),
    .wr_addr        (bc_wr_addr),
    .msg_addr       (bc_msg_addr),
    .msg_addr_valid (bc_msg_valid)
  );

  //////////////////////////////
  // Banks and their arbiters
  //////////////////////////////

  dmem_bank_arb #(.BANK_ID(1'b0)) i_arb0 (
    .bc_wr      (bc_wr),
    .bc_addr    (bc_wr_addr),
    .wr_valid   (wr_head_valid),
    .wr_head    (wr_head),
    .rd_valid   (rd_head_valid),
    .rd_head    (rd_head),
    .rd_room    (rd_room),
    .wr_gnt     (wr_gnt0),
    .rd_gnt     (rd_gnt0),
    .port_wr    (port_wr0),
    .port_rd_en (port_rd_en0)
  );

  dmem_bank_arb #(.BANK_ID(1'b1)) i_arb1 (
    .bc_wr      (bc_wr),
    .bc_addr    (bc_wr_addr),
    .wr_valid   (wr_head_valid),
    .wr_head    (wr_head),
    .rd_valid   (rd_head_valid),
    .rd_head    (rd_head),
    .rd_room    (rd_room),
    .wr_gnt     (wr_gnt1),
    .rd_gnt     (rd_gnt1),
    .port_wr    (port_wr1),
    .port_rd_en (port_rd_en1)
  );

  dmem_bank i_bank0 (
    .clk       (clk),
    .a_wr      (port_wr0),
    .a_rd_en   (port_rd_en0),
    .a_rd_data (bank0_a_rd),
    .b_en      (core_b0.en),
    .b_wen     (core_b0.wen),
    .b_idx     (core_b0.idx),
    .b_wr_data (core_b0.data),
    .b_rd_data (bank0_b_rd)
  );

  dmem_bank i_bank1 (
    .clk       (clk),
    .a_wr      (port_wr1),
    .a_rd_en   (port_rd_en1),
    .a_rd_data (bank1_a_rd),
    .b_en      (core_b1.en),
    .b_wen     (core_b1.wen),
    .b_idx     (core_b1.idx),
    .b_wr_data (core_b1.data),
    .b_rd_data (bank1_b_rd)
  );

  core_lane_port i_core_lane_port (
    .clk           (clk),
    .rst           (rst),
    .core_en       (core_en),
    .core_wen      (core_wen),
    .core_strb     (core_strb),
    .core_addr     (core_addr),
    .core_wr_data  (core_wr_data),
    .core_rd_data  (core_rd_data),
    .core_rd_valid (core_rd_valid),
    .bank0_b       (core_b0),
    .bank1_b       (core_b1),
    .bank0_rd      (bank0_b_rd),
    .bank1_rd      (bank1_b_rd)
  );

  dma_rd_return #(.DEPTH_LOG(RESP_DEPTH_LOG)) i_dma_rd_return (
    .clk        (clk),
    .rst        (rst),
    .rd_gnt0    (rd_gnt0),
    .rd_gnt1    (rd_gnt1),
    .bank0_rd   (bank0_a_rd),
    .bank1_rd   (bank1_a_rd),
    .rd_room    (rd_room),
    .resp_valid (dma_rd_resp_valid),
    .resp_data  (dma_rd_resp_data),
    .resp_ready (dma_rd_resp_ready)
  );

endmodule

`default_nettype wire

// File: hdl/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int DEPTH_LOG = 2,
  parameter int WIDTH     = 32
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 in_valid,
  input  logic [WIDTH-1:0]     in_data,
  output logic                 in_ready,

  output logic                 out_valid,
  output logic [WIDTH-1:0]     out_data,
  input  logic                 out_ready,

  output logic [DEPTH_LOG:0]   free_slots
);

  localparam logic [DEPTH_LOG:0] DEPTH = (DEPTH_LOG+1)'(2 ** DEPTH_LOG);

  logic [WIDTH-1:0]     mem [2**DEPTH_LOG];
  logic [DEPTH_LOG-1:0] wr_ptr;
  logic [DEPTH_LOG-1:0] rd_ptr;
  logic [DEPTH_LOG:0]   count;
  logic                 push;
  logic                 pop;

  assign in_ready   = (count != DEPTH);
  assign out_valid  = (count != '0);
  assign push       = in_valid && in_ready;
  assign pop        = out_valid && out_ready;
  assign out_data   = mem[rd_ptr];
  assign free_slots = DEPTH - count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
common/dmem_pkg.sv
hdl/sync_fifo.sv
hdl/bc_msg_stage.sv
dmem/dmem_bank_arb.sv
dmem/dmem_bank.sv
hdl/core_lane_port.sv
hdl/dma_rd_return.sv
hdl/dmem_sys.sv
bench/clk_gen.sv
bench/dmem_sys_properties.sv
bench/dmem_sys_tb.sv
